/* build.f */
+incdir+hw
hw/oc_pkg.sv
hw/oc_issue_alloc.sv
hw/oc_bank_arbiter.sv
hw/oc_collector_unit.sv
hw/oc_ex_dispatch.sv
hw/oc_top.sv
bench/tb_clkgen.sv
bench/tb_oc_top.sv

/* Bender.yml */
package:
  name: oc_collect

export_include_dirs:
  - hw

sources:
  - hw/oc_pkg.sv
  - hw/oc_issue_alloc.sv
  - hw/oc_bank_arbiter.sv
  - hw/oc_collector_unit.sv
  - hw/oc_ex_dispatch.sv
  - hw/oc_top.sv
  - target: test
    files:
      - bench/tb_clkgen.sv
      - bench/tb_oc_top.sv

/* bench/tb_oc_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "oc_macros.svh"

module tb_oc_top
	import oc_pkg::*;
();

	localparam int num_tests = 5;
	localparam int cycles_per_test = 400;
	localparam int handshake_limit = 200; // cycles before a handshake counts as stuck

	logic clk;
	logic rst;
	logic issue_req;
	issue_req_t issue_in;
	logic issue_ack;
	rf_wr_t rf_wr;
	logic ex_req;
	dispatch_t ex_out;
	logic ex_ack;

	oc_data_t rf_model [`OC_NUM_REGS]; // mirror of the register banks
	dispatch_t exp_q [$]; // issued but not yet dispatched
	logic [31:0] next_tag;
	int errors;
	int checks;
	int n_issued;
	int n_dispatched;
	logic hold_ack; // consumer stalls ex_ack while set
	int ack_delay_max;

	tb_clkgen #(
		.period_ns(40),
		.rst_cycles(10)
	) clkgen_i (
		.clk(clk),
		.rst(rst)
	);

	oc_top oc_top_i (
		.clk(clk),
		.rst(rst),
		.issue_req(issue_req),
		.issue_in(issue_in),
		.issue_ack(issue_ack),
		.rf_wr(rf_wr),
		.ex_req(ex_req),
		.ex_out(ex_out),
		.ex_ack(ex_ack)
	);

	task automatic step();
		@(posedge clk);
		#2; // drive and sample point
	endtask

	task automatic check_data(input string name, input oc_data_t exp, input oc_data_t got);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_dispatch(input dispatch_t exp, input dispatch_t got);
		checks++;
		if (got.pyld !== exp.pyld)
		begin
			errors++;
			$display("error at %0t: ex_out.pyld expected %h got %h", $time, exp.pyld, got.pyld);
		end
		check_data("ex_out.op0", exp.op0, got.op0);
		check_data("ex_out.op1", exp.op1, got.op1);
	endtask

	// zero when invalid, the special value when flagged, else the register
	function automatic oc_data_t expected_op(input issue_req_t r, input int s);
		if (!r.src_valid[s])
			return '0;
		if (r.spe_slot[s])
			return r.spe_value;
		return rf_model[r.src_reg[s]];
	endfunction

	function automatic oc_data_t rand_data();
		return {$urandom(), $urandom()};
	endfunction

	task automatic write_reg(input reg_addr_t addr, input oc_data_t data);
		rf_wr.en = 1'b1;
		rf_wr.addr = addr;
		rf_wr.data = data;
		rf_model[addr] = data;
		step();
		rf_wr.en = 1'b0;
	endtask

	task automatic build_req(input logic [1:0] valid, input logic [1:0] spe, input reg_addr_t r0,
		input reg_addr_t r1, output issue_req_t r);
		logic [31:0] rnd;
		rnd = $urandom();
		r.pyld.instr = next_tag; // unique tag per instruction
		next_tag++;
		r.pyld.warp_id = rnd[2:0];
		r.pyld.alu_op = rnd[6:3];
		r.pyld.imm = rnd[22:7];
		r.pyld.imm_valid = rnd[23];
		r.pyld.reg_write = rnd[24];
		r.pyld.dst = rnd[29:25];
		r.src_valid = valid;
		r.src_reg[0] = r0;
		r.src_reg[1] = r1;
		r.spe_slot = spe;
		r.spe_value = rand_data();
	endtask

	task automatic raise_issue(input issue_req_t r);
		dispatch_t exp;
		exp.pyld = r.pyld;
		exp.op0 = expected_op(r, 0);
		exp.op1 = expected_op(r, 1);
		exp_q.push_back(exp);
		n_issued++;
		issue_in = r;
		issue_req = 1'b1;
	endtask

	task automatic complete_issue();
		int n;
		n = 0;
		while (!issue_ack && n < handshake_limit)
		begin
			step();
			n++;
		end
		if (!issue_ack)
		begin
			errors++;
			$display("issue request with tag %h was never acknowledged", issue_in.pyld.instr);
		end
		issue_req = 1'b0;
		n = 0;
		while (issue_ack && n < handshake_limit)
		begin
			step();
			n++;
		end
		if (issue_ack)
		begin
			errors++;
			$display("issue_ack stayed high after issue_req was dropped");
		end
	endtask

	task automatic issue_instr(input logic [1:0] valid, input logic [1:0] spe,
		input reg_addr_t r0, input reg_addr_t r1);
		issue_req_t r;
		build_req(valid, spe, r0, r1, r);
		raise_issue(r);
		complete_issue();
	endtask

	// all issued work dispatched and the execution handshake back to rest
	task automatic wait_drain();
		int n;
		n = 0;
		while ((exp_q.size() != 0 || ex_req || ex_ack) && n < handshake_limit)
		begin
			step();
			n++;
		end
		if (exp_q.size() != 0)
		begin
			errors++;
			$display("%0d issued instructions were never dispatched", exp_q.size());
		end
	endtask

	task automatic match_dispatch(input dispatch_t got);
		int idx;
		idx = -1;
		n_dispatched++;
		for (int i = 0; i < exp_q.size(); i++)
		begin
			if (idx < 0 && exp_q[i].pyld.instr == got.pyld.instr)
				idx = i;
		end
		if (idx < 0)
		begin
			errors++;
			$display("dispatched tag %h matches no outstanding instruction", got.pyld.instr);
		end
		else
		begin
			check_dispatch(exp_q[idx], got);
			exp_q.delete(idx);
		end
	endtask

	task automatic test_register_sources();
		logic [31:0] rnd;
		reg_addr_t r0;
		for (int i = 0; i < `OC_NUM_REGS; i++)
			write_reg(i[4:0], rand_data());
		for (int k = 0; k < 8; k++)
		begin
			rnd = $urandom();
			r0 = rnd[4:0];
			issue_instr(2'b11, 2'b00, r0, {r0[4:2], r0[1:0] + 2'd1}); // neighbouring bank
		end
		wait_drain();
	endtask

	task automatic test_load_resolved();
		logic [31:0] rnd;
		rnd = $urandom();
		issue_instr(2'b00, 2'b00, rnd[4:0], rnd[9:5]);
		issue_instr(2'b00, 2'b11, rnd[9:5], rnd[14:10]); // flags ignored on invalid sources
		issue_instr(2'b01, 2'b01, rnd[14:10], rnd[19:15]);
		issue_instr(2'b10, 2'b10, rnd[19:15], rnd[24:20]);
		issue_instr(2'b11, 2'b11, rnd[24:20], rnd[29:25]);
		wait_drain();
	endtask

	task automatic test_bank_sharing();
		logic [31:0] rnd;
		reg_addr_t r0;
		for (int k = 0; k < 4; k++)
		begin
			rnd = $urandom();
			r0 = rnd[4:0];
			issue_instr(2'b11, 2'b00, r0, r0); // one read for both slots
			issue_instr(2'b11, 2'b00, r0, {~r0[4:2], r0[1:0]}); // other row, same bank
		end
		wait_drain();
	endtask

	task automatic test_back_pressure();
		issue_req_t r;
		int n;
		hold_ack = 1'b1;
		for (int k = 0; k < 3; k++)
			issue_instr(2'b11, 2'b00, 5'd4 + k[4:0], 5'd9 + k[4:0]);
		repeat (10)
			step();
		// both collectors full and one bundle waiting at the output
		build_req(2'b11, 2'b00, 5'd3, 5'd12, r);
		raise_issue(r);
		n = 0;
		repeat (20)
		begin
			step();
			if (issue_ack)
				n++;
		end
		checks++;
		if (n != 0)
		begin
			errors++;
			$display("issue_ack was given while every collector was still occupied");
		end
		hold_ack = 1'b0;
		complete_issue();
		wait_drain();
	endtask

	task automatic test_random_stream();
		logic [31:0] rnd;
		ack_delay_max = 4;
		for (int i = 0; i < 40; i++)
		begin
			if (i % 10 == 5)
			begin
				wait_drain(); // nothing outstanding while registers change
				for (int w = 0; w < 4; w++)
				begin
					rnd = $urandom();
					write_reg(rnd[4:0], rand_data());
				end
			end
			rnd = $urandom();
			issue_instr(rnd[1:0], rnd[3:2], rnd[8:4], rnd[13:9]);
		end
		wait_drain();
		checks++;
		if (n_dispatched != n_issued)
		begin
			errors++;
			$display("%0d instructions issued but %0d dispatched", n_issued, n_dispatched);
		end
		ack_delay_max = 0;
	endtask

	task automatic finish_test(input int num, input string name, input int err_before);
		if (errors == err_before)
			$display("test %0d %s: ok", num, name);
		else
			$display("test %0d %s: %0d errors", num, name, errors - err_before);
	endtask

	// execution side, takes each bundle and acknowledges after a delay
	initial
	begin : consumer
		int delay;
		@(posedge rst);
		forever
		begin
			step();
			if (ex_req && !ex_ack)
			begin
				match_dispatch(ex_out);
				delay = (ack_delay_max > 0) ? $urandom_range(ack_delay_max, 0) : 0;
				repeat (delay)
					step();
				while (hold_ack)
					step();
				ex_ack = 1'b1;
				step();
				while (ex_req)
					step();
				ex_ack = 1'b0;
			end
		end
	end

	initial
	begin : watchdog
		repeat (num_tests * cycles_per_test)
			@(posedge clk);
		$display("run stopped by the watchdog after %0d cycles", num_tests * cycles_per_test);
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin : main
		int seed_val;
		int err_before;
		seed_val = $urandom(32'h8d68);
		issue_req = 1'b0;
		issue_in = '0;
		rf_wr = '0;
		ex_ack = 1'b0;
		hold_ack = 1'b0;
		ack_delay_max = 0;
		errors = 0;
		checks = 0;
		n_issued = 0;
		n_dispatched = 0;
		next_tag = 32'h0000_1000;
		for (int i = 0; i < `OC_NUM_REGS; i++)
			rf_model[i] = '0;
		step();
		while (!rst)
			step();
		step();

		err_before = errors;
		test_register_sources();
		finish_test(1, "register sources", err_before);
		err_before = errors;
		test_load_resolved();
		finish_test(2, "sources resolved at load", err_before);
		err_before = errors;
		test_bank_sharing();
		finish_test(3, "same register and same bank", err_before);
		err_before = errors;
		test_back_pressure();
		finish_test(4, "back-pressure", err_before);
		err_before = errors;
		test_random_stream();
		finish_test(5, "random stream", err_before);

		$display("tests %0d, checks %0d, errors %0d", num_tests, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int period_ns = 40,
	parameter int rst_cycles = 10
)
(
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever
			#(period_ns / 2) clk = ~clk;
	end

	initial
	begin
		rst = 1'b0; // active low
		repeat (rst_cycles)
			@(posedge clk);
		#2 rst = 1'b1; // released just after an edge, like the other inputs
	end

endmodule

`default_nettype wire

/* hw/oc_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "oc_macros.svh"

module oc_top
	import oc_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire issue_req,
	input issue_req_t issue_in,
	output logic issue_ack,
	input rf_wr_t rf_wr,
	output logic ex_req,
	output dispatch_t ex_out,
	input wire ex_ack
);

	logic [`OC_NUM_CU-1:0] cu_busy;
	logic [`OC_NUM_CU-1:0] cu_rdy;
	logic [`OC_NUM_CU-1:0] cu_re;
	logic [`OC_NUM_CU-1:0][1:0] cu_we;
	issue_req_t cu_load; // shared load bus to all collectors
	slot_req_t slot_req [`OC_NUM_CU][2];
	bank_rd_t bank_rd [`OC_NUM_BANKS];
	logic [`OC_NUM_BANKS-1:0] same_oc;
	dispatch_t cu_out [`OC_NUM_CU];

	oc_issue_alloc issue_alloc_i (
		.clk(clk),
		.rst(rst),
		.issue_req(issue_req),
		.issue_in(issue_in),
		.issue_ack(issue_ack),
		.cu_busy(cu_busy),
		.cu_we(cu_we),
		.cu_load(cu_load)
	);

	oc_bank_arbiter bank_arbiter_i (
		.clk(clk),
		.rst(rst),
		.slot_req(slot_req),
		.rf_wr(rf_wr),
		.bank_rd(bank_rd),
		.same_oc(same_oc)
	);

	for (genvar i = 0; i < `OC_NUM_CU; i++)
	begin : g_cu
		oc_collector_unit #(
			.cu_id(i)
		) collector_i (
			.clk(clk),
			.rst(rst),
			.we(cu_we[i]),
			.re(cu_re[i]),
			.load(cu_load),
			.bank_rd(bank_rd),
			.same_oc(same_oc),
			.slot_req(slot_req[i]),
			.busy(cu_busy[i]),
			.rdy(cu_rdy[i]),
			.cu_out(cu_out[i])
		);
	end

	oc_ex_dispatch ex_dispatch_i (
		.clk(clk),
		.rst(rst),
		.cu_rdy(cu_rdy),
		.cu_out(cu_out),
		.cu_re(cu_re),
		.ex_req(ex_req),
		.ex_out(ex_out),
		.ex_ack(ex_ack)
	);

endmodule

`default_nettype wire

/* hw/oc_ex_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "oc_macros.svh"

module oc_ex_dispatch
	import oc_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire [`OC_NUM_CU-1:0] cu_rdy,
	input dispatch_t cu_out [`OC_NUM_CU],
	output logic [`OC_NUM_CU-1:0] cu_re,
	output logic ex_req,
	output dispatch_t ex_out,
	input wire ex_ack
);

	typedef enum logic [1:0] {
		EX_IDLE,
		EX_REQ,
		EX_ACK_LOW
	} ex_st_t;

	ex_st_t state;
	logic rdy_any;
	logic [$clog2(`OC_NUM_CU)-1:0] rdy_idx;
	logic take;

	// fixed priority, collector 0 first
	always_comb
	begin
		rdy_any = 1'b0;
		rdy_idx = '0;
		for (int i = `OC_NUM_CU - 1; i >= 0; i--)
		begin
			if (cu_rdy[i])
			begin
				rdy_any = 1'b1;
				rdy_idx = i[$clog2(`OC_NUM_CU)-1:0];
			end
		end
	end

	assign take = (state == EX_IDLE) && rdy_any && !ex_ack;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state <= EX_IDLE;
			ex_req <= 1'b0;
			cu_re <= '0;
		end
		else
		begin
			cu_re <= '0; // single-cycle release pulse
			case (state)
				EX_IDLE:
					if (take)
					begin
						cu_re[rdy_idx] <= 1'b1;
						ex_req <= 1'b1;
						state <= EX_REQ;
					end
				EX_REQ:
					if (ex_ack)
					begin
						ex_req <= 1'b0;
						state <= EX_ACK_LOW;
					end
				EX_ACK_LOW:
					if (!ex_ack)
						state <= EX_IDLE;
				default:
					state <= EX_IDLE;
			endcase
		end
	end

	// bundle held here while the collector is recycled
	always_ff @(posedge clk)
	begin
		if (take)
			ex_out <= cu_out[rdy_idx];
	end

endmodule

`default_nettype wire

/* hw/oc_collector_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "oc_macros.svh"

module oc_collector_unit
	import oc_pkg::*;
#(
	parameter int cu_id = 0
)
(
	input wire clk,
	input wire rst,
	input wire [1:0] we,
	input wire re,
	input issue_req_t load,
	input bank_rd_t bank_rd [`OC_NUM_BANKS],
	input wire [`OC_NUM_BANKS-1:0] same_oc,
	output slot_req_t slot_req [2],
	output logic busy,
	output logic rdy,
	output dispatch_t cu_out
);

	localparam ocid_t base_id = ocid_t'(2 * cu_id); // slot 0 ocid, slot 1 is base + 1

	instr_pyld_t pyld;
	oc_data_t op [2];
	reg_addr_t src [2];
	logic [1:0] pending;
	logic [1:0] hit;
	oc_data_t hit_data [2];
	logic [1:0] use_reg; // slot sourced from the register file

	always_comb
	begin
		for (int s = 0; s < 2; s++)
			use_reg[s] = we[s] && load.src_valid[s] && !load.spe_slot[s];
	end

	// match the bank broadcast against each slot
	always_comb
	begin
		for (int s = 0; s < 2; s++)
		begin
			hit[s] = 1'b0;
			hit_data[s] = '0;
			for (int b = 0; b < `OC_NUM_BANKS; b++)
			begin
				if (bank_rd[b].vld && bank_of(src[s]) == bank_id_t'(b)
					&& (bank_rd[b].ocid == (base_id | ocid_t'(s))
					|| (s == 1 && same_oc[b] && bank_rd[b].ocid == base_id)))
				begin
					hit[s] = 1'b1;
					hit_data[s] = bank_rd[b].data;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			busy <= 1'b0;
			pending <= 2'b00;
		end
		else if (we != 2'b00)
		begin
			busy <= 1'b1;
			pending <= use_reg;
		end
		else if (re)
		begin
			busy <= 1'b0;
			pending <= 2'b00;
		end
		else
			pending <= pending & ~hit; // drops in the capture cycle
	end

	always_ff @(posedge clk)
	begin
		if (we != 2'b00)
		begin
			pyld <= load.pyld;
			for (int s = 0; s < 2; s++)
			begin
				src[s] <= load.src_reg[s];
				if (we[s] && load.src_valid[s] && load.spe_slot[s])
					op[s] <= load.spe_value;
				else
					op[s] <= '0; // invalid source reads as zero
			end
		end
		else
		begin
			for (int s = 0; s < 2; s++)
			begin
				if (pending[s] && hit[s])
					op[s] <= hit_data[s];
			end
		end
	end

	always_comb
	begin
		for (int s = 0; s < 2; s++)
		begin
			slot_req[s].pending = pending[s];
			slot_req[s].addr = src[s];
		end
	end

	assign rdy = busy && (pending == 2'b00);

	assign cu_out.pyld = pyld;
	assign cu_out.op0 = op[0];
	assign cu_out.op1 = op[1];

endmodule

`default_nettype wire

/* hw/oc_bank_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "oc_macros.svh"

module oc_bank_arbiter
	import oc_pkg::*;
(
	input wire clk,
	input wire rst,
	input slot_req_t slot_req [`OC_NUM_CU][2],
	input rf_wr_t rf_wr,
	output bank_rd_t bank_rd [`OC_NUM_BANKS],
	output logic [`OC_NUM_BANKS-1:0] same_oc
);

	localparam int num_req = `OC_NUM_CU * 2;

	oc_data_t mem [`OC_NUM_BANKS][`OC_BANK_ROWS];

	logic [num_req-1:0] req;
	logic [num_req-1:0] inflight; // granted last cycle, data on the bus now
	logic [num_req-1:0] inflight_nxt;
	logic [`OC_NUM_BANKS-1:0] gnt_vld;
	logic [`OC_NUM_BANKS-1:0] gnt_same;
	ocid_t gnt_id [`OC_NUM_BANKS];
	reg_addr_t gnt_addr [`OC_NUM_BANKS];

	always_comb
	begin
		for (int i = 0; i < num_req; i++)
			req[i] = slot_req[i / 2][i % 2].pending && !inflight[i];

		inflight_nxt = '0;
		for (int b = 0; b < `OC_NUM_BANKS; b++)
		begin
			gnt_vld[b] = 1'b0;
			gnt_same[b] = 1'b0;
			gnt_id[b] = '0;
			gnt_addr[b] = '0;
			// walk downwards so the lowest ocid is assigned last
			for (int i = num_req - 1; i >= 0; i--)
			begin
				if (req[i] && bank_of(slot_req[i / 2][i % 2].addr) == bank_id_t'(b))
				begin
					gnt_vld[b] = 1'b1;
					gnt_id[b] = ocid_t'(i);
					gnt_addr[b] = slot_req[i / 2][i % 2].addr;
					// slot 0 winner may carry slot 1 of the same collector along
					gnt_same[b] = (i % 2 == 0) && req[i | 1]
						&& slot_req[i / 2][1].addr == slot_req[i / 2][0].addr;
				end
			end
			if (gnt_vld[b])
			begin
				inflight_nxt[gnt_id[b]] = 1'b1;
				if (gnt_same[b])
					inflight_nxt[gnt_id[b] + 1'b1] = 1'b1;
			end
		end
	end

	// write lands at the edge, so a same-cycle read sees the old row
	always_ff @(posedge clk)
	begin
		if (rf_wr.en)
			mem[bank_of(rf_wr.addr)][row_of(rf_wr.addr)] <= rf_wr.data;
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			inflight <= '0;
			same_oc <= '0;
			for (int b = 0; b < `OC_NUM_BANKS; b++)
				bank_rd[b].vld <= 1'b0;
		end
		else
		begin
			inflight <= inflight_nxt;
			same_oc <= gnt_same;
			for (int b = 0; b < `OC_NUM_BANKS; b++)
				bank_rd[b].vld <= gnt_vld[b];
		end
		for (int b = 0; b < `OC_NUM_BANKS; b++)
		begin
			bank_rd[b].ocid <= gnt_id[b];
			bank_rd[b].data <= mem[b][row_of(gnt_addr[b])];
		end
	end

endmodule

`default_nettype wire

/* hw/oc_issue_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "oc_macros.svh"

module oc_issue_alloc
	import oc_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire issue_req,
	input issue_req_t issue_in,
	output logic issue_ack,
	input wire [`OC_NUM_CU-1:0] cu_busy,
	output logic [`OC_NUM_CU-1:0][1:0] cu_we,
	output issue_req_t cu_load
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_ACK,
		ST_WAIT_LOW
	} st_t;

	st_t state;
	logic free_any;
	logic [$clog2(`OC_NUM_CU)-1:0] free_idx;
	logic [$clog2(`OC_NUM_CU)-1:0] sel; // collector being loaded
	logic [1:0] mask;
	logic take;

	// lowest-numbered idle collector wins
	always_comb
	begin
		free_any = 1'b0;
		free_idx = '0;
		for (int i = `OC_NUM_CU - 1; i >= 0; i--)
		begin
			if (!cu_busy[i])
			begin
				free_any = 1'b1;
				free_idx = i[$clog2(`OC_NUM_CU)-1:0];
			end
		end
	end

	assign take = (state == ST_IDLE) && issue_req && free_any;

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= ST_IDLE;
		else
		begin
			case (state)
				ST_IDLE:
					if (take)
						state <= ST_LOAD;
				ST_LOAD:
					state <= ST_ACK; // we pulse lasts exactly this cycle
				ST_ACK:
					if (!issue_req)
						state <= ST_WAIT_LOW;
				ST_WAIT_LOW:
					state <= ST_IDLE; // ack already low, one turnaround cycle
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// request captured once, at acceptance
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			cu_load <= issue_in;
			sel <= free_idx;
			mask <= (issue_in.src_valid == 2'b00) ? 2'b11 : issue_in.src_valid;
		end
	end

	always_comb
	begin
		for (int i = 0; i < `OC_NUM_CU; i++)
			cu_we[i] = (state == ST_LOAD && sel == i) ? mask : 2'b00;
	end

	assign issue_ack = (state == ST_ACK);

endmodule

`default_nettype wire

/* hw/oc_pkg.sv */
`default_nettype none

`include "oc_macros.svh"

package oc_pkg;

	typedef logic [$clog2(`OC_NUM_REGS)-1:0] reg_addr_t; // row in upper bits, bank in low bits
	typedef logic [$clog2(`OC_NUM_BANKS)-1:0] bank_id_t;
	typedef logic [$clog2(`OC_BANK_ROWS)-1:0] bank_row_t;
	typedef logic [`OC_DATA_W-1:0] oc_data_t;
	typedef logic [$clog2(`OC_NUM_CU):0] ocid_t; // collector number, then slot

	typedef struct packed {
		logic [31:0] instr; // doubles as the tag
		logic [2:0] warp_id;
		logic [3:0] alu_op;
		logic [15:0] imm;
		logic imm_valid;
		logic reg_write;
		logic [4:0] dst;
	} instr_pyld_t;

	typedef struct packed {
		instr_pyld_t pyld;
		logic [1:0] src_valid;
		reg_addr_t [1:0] src_reg;
		logic [1:0] spe_slot; // slot takes spe_value instead of a register
		oc_data_t spe_value;
	} issue_req_t;

	typedef struct packed {
		logic vld;
		ocid_t ocid;
		oc_data_t data;
	} bank_rd_t;

	typedef struct packed {
		logic pending;
		reg_addr_t addr;
	} slot_req_t;

	typedef struct packed {
		instr_pyld_t pyld;
		oc_data_t op0;
		oc_data_t op1;
	} dispatch_t;

	typedef struct packed {
		logic en;
		reg_addr_t addr;
		oc_data_t data;
	} rf_wr_t;

	function automatic bank_id_t bank_of(input reg_addr_t r);
		return r[$bits(bank_id_t)-1:0];
	endfunction

	function automatic bank_row_t row_of(input reg_addr_t r);
		return r[$bits(reg_addr_t)-1 -: $bits(bank_row_t)];
	endfunction

endpackage

`default_nettype wire

/* hw/oc_macros.svh */
`ifndef OC_MACROS_SVH
`define OC_MACROS_SVH

// operand width in bits
`define OC_DATA_W 64

// register file banking
`define OC_NUM_BANKS 4
`define OC_BANK_ROWS 8

// architectural registers, spread over the banks by the low address bits
`define OC_NUM_REGS 32

// collector units acting as the operand buffer
`define OC_NUM_CU 2

`endif
